// File: verilog/spi_pkg.sv
package spi_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths shared by the bus, the registers and the shift engine.
    ////////////////////////////////////////////////////////////////////

    localparam int DATA_W      = 8; // Data word and register word width.
    localparam int ADDR_W      = 2; // Wishbone word address width.
    localparam int PRESC_EXP_W = 3; // Prescaler exponent, half period is 2**n clocks.

    // Register map.
    localparam logic [ADDR_W-1:0] ADDR_DATA = 2'd0; // Transmit buffer and receive register.
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 2'd1; // Control word.
    localparam logic [ADDR_W-1:0] ADDR_STAT = 2'd2; // Status word and senderr clear.

    // Control word, as written by the host.
    typedef struct packed {
        logic [1:0]             pad;      // Reads back as written.
        logic [PRESC_EXP_W-1:0] prescale; // SCK half period exponent.
        logic [1:0]             mode;     // Bit 1 is polarity, bit 0 is phase.
        logic                   lsbfirst; // Shift order, 1 sends bit 0 first.
    } spi_ctrl_t;

    // Status word, assembled on every read.
    typedef struct packed {
        logic [3:0] pad;
        logic       busy;         // A frame is on the wire.
        logic       senderr;      // Sticky, a data write hit a full buffer.
        logic       charreceived; // Unread byte in the receive register.
        logic       buffempty;    // Transmit buffer can take a byte.
    } spi_stat_t;

    // One Wishbone data word seen three ways.
    // The register decoder picks the view from the address.
    typedef union packed {
        logic [DATA_W-1:0] data;
        spi_ctrl_t         ctrl;
        spi_stat_t         stat;
    } reg_word_u;

endpackage

// File: verilog/spi_frame_if.sv
// One queued frame on its way from the transmit buffer to the shift engine.
// The control fields travel with the byte, so a frame keeps the settings
// that were in force when it was written.
interface spi_frame_if;
    import spi_pkg::*;

    logic                   valid;    // Transmit buffer holds a frame.
    logic [DATA_W-1:0]      data;     // Byte to send.
    logic [PRESC_EXP_W-1:0] prescale; // Half period exponent for this frame.
    logic [1:0]             mode;     // Polarity and phase for this frame.
    logic                   lsbfirst; // Shift order for this frame.
    logic                   take;     // Engine copies the frame in this cycle.

    // Bus side owns the buffer.
    modport source (
        output valid, data, prescale, mode, lsbfirst,
        input  take
    );

    // Shift engine pulls frames.
    modport sink (
        input  valid, data, prescale, mode, lsbfirst,
        output take
    );

endinterface

// File: verilog/spi_bus_regs.sv
module spi_bus_regs (
    input  logic                        wr,
    input  logic                        rst,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [spi_pkg::ADDR_W-1:0]  adr,
    input  logic [spi_pkg::DATA_W-1:0]  dat_w,
    output logic [spi_pkg::DATA_W-1:0]  dat_r,
    output logic                        ack,
    input  logic [spi_pkg::DATA_W-1:0]  rx_byte,
    input  logic                        rx_full,
    output logic                        rx_pop,
    input  logic                        busy,
    spi_frame_if.source                 frame
);
    import spi_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // Wishbone decode.
    ////////////////////////////////////////////////////////////////////

    logic       access;   // First cycle of a bus cycle, before ack.
    logic       wr_en;    // Register write takes effect on this edge.
    logic       rd_en;    // Register read is captured on this edge.
    reg_word_u  wr_word;  // Host word in all three views.
    reg_word_u  rd_word;  // Word returned to the host.
    spi_stat_t  stat_w;   // Live status.
    spi_ctrl_t  ctrl_q;   // Control register.
    spi_ctrl_t  tx_ctrl;  // Control copy that belongs to the queued byte.
    logic [DATA_W-1:0] tx_data; // Transmit buffer.
    logic       tx_full;  // Transmit buffer holds a byte.
    logic       senderr;  // Sticky overrun of the transmit buffer.

    assign access = cyc && stb && !ack; // A single wait cycle, never more.
    assign wr_en  = access && we;
    assign rd_en  = access && !we;
    assign wr_word = dat_w;

    // Reading the data register consumes the received byte.
    assign rx_pop = rd_en && (adr == ADDR_DATA);

    // Status is built fresh from local state and the other two blocks.
    always_comb begin
        stat_w              = '0;
        stat_w.busy         = busy;
        stat_w.senderr      = senderr;
        stat_w.charreceived = rx_full;
        stat_w.buffempty    = !tx_full;
    end

    always_comb begin
        rd_word = '0; // Unmapped address reads zero.
        case (adr)
            ADDR_DATA: rd_word.data = rx_byte;
            ADDR_CTRL: rd_word.ctrl = ctrl_q;
            ADDR_STAT: rd_word.stat = stat_w;
            default:   rd_word.data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Control state.
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            ack     <= 1'b0;
            ctrl_q  <= '0;
            tx_full <= 1'b0;
            senderr <= 1'b0;
        end else begin
            ack <= access; // Registered, one cycle after the request.
            if (frame.take) begin
                tx_full <= 1'b0; // Engine has its copy now.
            end
            if (wr_en) begin
                case (adr)
                    ADDR_DATA: begin
                        if (tx_full) begin
                            senderr <= 1'b1; // Word is dropped.
                        end else begin
                            tx_full <= 1'b1;
                        end
                    end
                    ADDR_CTRL: ctrl_q <= wr_word.ctrl;
                    ADDR_STAT: begin
                        if (wr_word.stat.senderr) begin
                            senderr <= 1'b0; // Write one to clear.
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Buffer payload and read data.
    always_ff @(posedge wr) begin
        if (wr_en && (adr == ADDR_DATA) && !tx_full) begin
            tx_data <= wr_word.data;
            tx_ctrl <= ctrl_q; // Frame settings are frozen here.
        end
        if (rd_en) begin
            dat_r <= rd_word.data;
        end
    end

    assign frame.valid    = tx_full;
    assign frame.data     = tx_data;
    assign frame.prescale = tx_ctrl.prescale;
    assign frame.mode     = tx_ctrl.mode;
    assign frame.lsbfirst = tx_ctrl.lsbfirst;

    // An acknowledge only ever answers a request seen on the edge before.
    a_ack_request : assert property (
        @(posedge wr) disable iff (rst)
        $rose(ack) |-> $past(cyc && stb)
    ) else $error("ack rose without a preceding cyc and stb");

endmodule

// File: verilog/spi_shift_engine.sv
module spi_shift_engine #(
    parameter int presc_w = 8 // Prescaler counter width, must hold 2**7.
) (
    input  logic                        wr,
    input  logic                        rst,
    input  logic                        miso,
    spi_frame_if.sink                   frame,
    output logic                        sck,
    output logic                        mosi,
    output logic                        ss,
    output logic                        busy,
    output logic                        rx_push,
    output logic [spi_pkg::DATA_W-1:0]  rx_data
);
    import spi_pkg::*;

    // One step of the output shift register in the chosen order.
    // The vacated end fills with ones, the idle level of mosi.
    function automatic logic [DATA_W-1:0] shift_next(
        input logic [DATA_W-1:0] word,
        input logic              lsb
    );
        if (lsb) begin
            return {1'b1, word[DATA_W-1:1]};
        end
        return {word[DATA_W-2:0], 1'b1};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Frame state.
    ////////////////////////////////////////////////////////////////////

    logic                   busy_q;    // 1 while a frame is on the wire.
    logic [presc_w-1:0]     presc_cnt; // Clocks within the current half period.
    logic [presc_w-1:0]     presc_top; // Last count of a half period.
    logic [4:0]             phase_cnt; // Bit 0 is SCK phase, bits 4..1 count bits.
    logic [PRESC_EXP_W-1:0] ps_q;      // Frame copy of the prescaler exponent.
    logic                   pol_q;     // Frame copy of polarity.
    logic                   pha_q;     // Frame copy of phase.
    logic                   lsb_q;     // Frame copy of shift order.
    logic                   mosi_q;    // Bit on the wire.
    logic [DATA_W-1:0]      shift_out; // Bits still to send.
    logic [DATA_W-1:0]      shift_in;  // Bits collected from miso.
    logic                   take;
    logic                   tick;        // Half period ends on this edge.
    logic                   sample_edge; // SCK edge that samples miso.
    logic                   shift_edge;  // SCK edge that moves mosi.
    logic                   last_half;   // Final half period of the frame.
    logic                   frame_done;
    logic                   first_bit;   // Leading bit of the incoming frame.
    logic                   out_bit;     // Next bit to present on mosi.

    // Hold off one cycle after a frame so rx_push and take never overlap.
    assign take = !busy_q && frame.valid && !rx_push;
    assign frame.take = take;

    assign presc_top = (presc_w'(1) << ps_q) - presc_w'(1); // 2**n clocks per half.
    assign tick = busy_q && (presc_cnt == presc_top);

    // Phase 0 samples on even to odd, phase 1 on odd to even.
    assign sample_edge = tick && (phase_cnt[0] == pha_q);
    assign shift_edge  = tick && (phase_cnt[0] != pha_q);
    assign last_half   = (phase_cnt[4:1] == 4'(DATA_W - 1)) && phase_cnt[0];
    assign frame_done  = tick && last_half;

    assign first_bit = frame.lsbfirst ? frame.data[0] : frame.data[DATA_W-1];
    assign out_bit   = lsb_q ? shift_out[0] : shift_out[DATA_W-1];

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            busy_q    <= 1'b0;
            ss        <= 1'b1;
            presc_cnt <= '0;
            phase_cnt <= '0;
            ps_q      <= '0;
            pol_q     <= 1'b0; // SCK idles low out of reset.
            pha_q     <= 1'b0;
            lsb_q     <= 1'b0;
            mosi_q    <= 1'b1;
            rx_push   <= 1'b0;
        end else begin
            rx_push <= frame_done; // Lands in the first idle cycle.
            if (take) begin
                busy_q    <= 1'b1;
                ss        <= 1'b0;
                presc_cnt <= '0;
                phase_cnt <= '0;
                ps_q      <= frame.prescale;
                pol_q     <= frame.mode[1];
                pha_q     <= frame.mode[0];
                lsb_q     <= frame.lsbfirst;
                // Phase 0 shows the first bit from SS falling.
                // Phase 1 waits for the leading edge.
                mosi_q    <= frame.mode[0] ? 1'b1 : first_bit;
            end else if (tick) begin
                presc_cnt <= '0;
                if (shift_edge) begin
                    mosi_q <= out_bit;
                end
                if (last_half) begin
                    busy_q    <= 1'b0;
                    phase_cnt <= '0;           // SCK back at its idle level.
                    ss        <= !frame.valid; // Stay selected for a queued byte.
                end else begin
                    phase_cnt <= phase_cnt + 5'd1;
                end
            end else if (busy_q) begin
                presc_cnt <= presc_cnt + presc_w'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Shift registers.
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge wr) begin
        if (take) begin
            // In phase 0 the first bit is already on mosi.
            shift_out <= frame.mode[0] ? frame.data : shift_next(frame.data, frame.lsbfirst);
        end else if (shift_edge) begin
            shift_out <= shift_next(shift_out, lsb_q);
        end
        if (sample_edge) begin
            if (lsb_q) begin
                shift_in <= {miso, shift_in[DATA_W-1:1]}; // First bit ends up in bit 0.
            end else begin
                shift_in <= {shift_in[DATA_W-2:0], miso}; // First bit ends up on top.
            end
        end
    end

    assign rx_data = shift_in; // Complete and stable while rx_push is high.
    assign busy    = busy_q;
    assign sck     = pol_q ^ phase_cnt[0];
    assign mosi    = ss ? 1'b1 : mosi_q; // Released line idles high.

    // SS is asserted for the whole of every frame.
    a_busy_ss : assert property (
        @(posedge wr) disable iff (rst)
        busy |-> !ss
    ) else $error("frame running with ss high");

    // A take empties the buffer, and no write can refill it on that same edge.
    a_take_valid : assert property (
        @(posedge wr) disable iff (rst)
        take |-> frame.valid ##1 !frame.valid
    ) else $error("take without a full buffer");

endmodule

// File: verilog/spi_rx_buffer.sv
module spi_rx_buffer (
    input  logic                        wr,
    input  logic                        rst,
    input  logic                        rx_push,
    input  logic [spi_pkg::DATA_W-1:0]  rx_data,
    input  logic                        rx_pop,
    output logic [spi_pkg::DATA_W-1:0]  rx_byte,
    output logic                        rx_full
);
    import spi_pkg::*;

    // Received flag. A new byte wins over a read in the same cycle,
    // so the host never loses track of data it has not seen.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            rx_full <= 1'b0;
        end else if (rx_push) begin
            rx_full <= 1'b1;
        end else if (rx_pop) begin
            rx_full <= 1'b0;
        end
    end

    // Holding register, simply overwritten when the host falls behind.
    always_ff @(posedge wr) begin
        if (rx_push) begin
            rx_byte <= rx_data;
        end
    end

    // Frames are at least a take plus 2*DATA_W half periods long,
    // so two pushes are never closer than that.
    a_push_spacing : assert property (
        @(posedge wr) disable iff (rst)
        rx_push |=> !rx_push [*2*DATA_W]
    ) else $error("rx_push pulses closer than one frame");

endmodule

// File: verilog/spi_master_top.sv
module spi_master_top #(
    parameter int presc_w = 8 // Prescaler counter width in the engine.
) (
    input  logic                        wr,
    input  logic                        rst,
    // Wishbone classic slave.
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [spi_pkg::ADDR_W-1:0]  adr,
    input  logic [spi_pkg::DATA_W-1:0]  dat_w,
    output logic [spi_pkg::DATA_W-1:0]  dat_r,
    output logic                        ack,
    // SPI master pins.
    output logic                        sck,
    output logic                        mosi,
    input  logic                        miso,
    output logic                        ss
);
    import spi_pkg::*;

    logic              busy;    // Engine running a frame.
    logic              rx_push; // Frame finished.
    logic [DATA_W-1:0] rx_data; // Byte shifted in.
    logic              rx_pop;  // Host read of the data register.
    logic [DATA_W-1:0] rx_byte; // Held receive byte.
    logic              rx_full; // Unread byte present.

    spi_frame_if frame ();

    spi_bus_regs spi_bus_regs_inst (
        .wr      (wr),
        .rst     (rst),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .rx_byte (rx_byte),
        .rx_full (rx_full),
        .rx_pop  (rx_pop),
        .busy    (busy),
        .frame   (frame)
    );

    spi_shift_engine #(
        .presc_w (presc_w)
    ) spi_shift_engine_inst (
        .wr      (wr),
        .rst     (rst),
        .miso    (miso),
        .frame   (frame),
        .sck     (sck),
        .mosi    (mosi),
        .ss      (ss),
        .busy    (busy),
        .rx_push (rx_push),
        .rx_data (rx_data)
    );

    spi_rx_buffer spi_rx_buffer_inst (
        .wr      (wr),
        .rst     (rst),
        .rx_push (rx_push),
        .rx_data (rx_data),
        .rx_pop  (rx_pop),
        .rx_byte (rx_byte),
        .rx_full (rx_full)
    );

endmodule

// File: bench/spi_slave_model.sv
// SPI slave model for the testbench.
// It looks at the SPI lines in the middle of each clock cycle, where they are stable,
// so an edge of SCK is seen one half cycle after the master makes it.
module spi_slave_model (
    input  logic                       wr,        // System clock, only used to sample.
    input  logic                       sck,
    input  logic                       mosi,
    input  logic                       ss,
    output logic                       miso,
    input  logic [1:0]                 mode,      // Mode under test, bit 1 is polarity.
    input  logic                       lsbfirst,
    input  logic [spi_pkg::DATA_W-1:0] resp,      // Byte sent back on every frame.
    output logic [spi_pkg::DATA_W-1:0] cap_byte,  // Last byte seen on mosi.
    output int                         cap_count, // Bytes seen since time zero.
    output logic                       idle_sck,  // SCK level just after SS fell.
    output int                         edge_gap   // Cycles between the first two edges.
);
    timeunit 1ns;
    timeprecision 1ps;
    import spi_pkg::*;

    logic              sck_prev  = 1'b0;
    logic              ss_prev   = 1'b1;
    logic              mosi_prev = 1'b1; // Mosi half a cycle before the edge.
    logic              in_clk    = 1'b0; // SCK is away from its idle level.
    logic              lead;
    logic              trail;
    logic [DATA_W-1:0] cap_sh    = '0;
    int                in_cnt    = 0;
    int                out_cnt   = 0;
    int                edge_num  = 0;
    int                gap_cnt   = 0;

    // Bit of the response that goes out in position idx of the frame.
    function automatic logic resp_bit(input int idx);
        return lsbfirst ? resp[idx] : resp[DATA_W-1-idx];
    endfunction

    initial begin
        miso      = 1'b1;
        cap_byte  = '0;
        cap_count = 0;
        idle_sck  = 1'b0;
        edge_gap  = 0;
        forever begin
            @(negedge wr);
            if (ss_prev && !ss) begin // A new selection starts a new frame.
                idle_sck = sck;
                in_cnt   = 0;
                out_cnt  = 0;
                edge_num = 0;
                in_clk   = 1'b0;
                if (!mode[0]) begin
                    miso    = resp_bit(0); // Phase 0 shows the first bit at once.
                    out_cnt = 1;
                end
            end
            gap_cnt = gap_cnt + 1;
            // The polarity change at a frame start moves SCK to idle, so it is no edge.
            lead  = !ss && (sck != sck_prev) && (sck != mode[1]);
            trail = (sck != sck_prev) && (sck == mode[1]) && in_clk;
            if (lead || trail) begin
                if (edge_num == 0) begin
                    gap_cnt = 0;
                end else if (edge_num == 1) begin
                    edge_gap = gap_cnt;
                end
                edge_num = edge_num + 1;
                in_clk   = lead;
            end
            if ((lead && mode[0]) || (trail && !mode[0])) begin // Shift edge.
                miso    = resp_bit(out_cnt);
                out_cnt = (out_cnt + 1) % DATA_W; // Wraps into the next frame.
            end
            if ((lead && !mode[0]) || (trail && mode[0])) begin // Sample edge.
                cap_sh = lsbfirst ? {mosi_prev, cap_sh[DATA_W-1:1]}
                                  : {cap_sh[DATA_W-2:0], mosi_prev};
                in_cnt = in_cnt + 1;
                if (in_cnt == DATA_W) begin
                    cap_byte  = cap_sh;
                    cap_count = cap_count + 1;
                    in_cnt    = 0;
                end
            end
            sck_prev  = sck;
            ss_prev   = ss;
            mosi_prev = mosi;
        end
    end

endmodule

// File: bench/spi_master_tb.sv
module spi_master_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spi_pkg::*;

    localparam int ACK_LIMIT   = 16;   // A bus access needs two cycles.
    localparam int FRAME_LIMIT = 4096; // Longest frame is 16 half periods of 128 cycles.
    localparam int N_ROWS      = 12;   // Eight fixed rows, then four random ones.

    // One row of the stimulus table.
    typedef struct {
        logic [DATA_W-1:0]      tx;    // Byte the host sends.
        logic [DATA_W-1:0]      resp;  // Byte the slave answers with.
        logic [1:0]             mode;  // Polarity and phase.
        logic                   lsb;   // Shift order.
        logic [PRESC_EXP_W-1:0] presc; // Half period exponent.
    } row_t;

    logic              wr = 1'b0;
    logic              rst;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;
    logic [DATA_W-1:0] dat_r;
    logic              ack;
    logic              sck;
    logic              mosi;
    logic              miso;
    logic              ss;
    logic [1:0]        mode;     // Slave model settings.
    logic              lsbfirst;
    logic [DATA_W-1:0] resp;
    logic [DATA_W-1:0] cap_byte;
    int                cap_count;
    logic              idle_sck;
    int                edge_gap;

    row_t        rows [N_ROWS];
    logic [31:0] lfsr = 32'hc08d_6912;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          err_mark = 0; // Error count when the current test began.
    int          ss_rises = 0;

    always #2 wr = ~wr; // 4 ns period.
    always @(posedge ss) ss_rises = ss_rises + 1;

    spi_master_top #(.presc_w(8)) spi_master_top_inst (.*);
    spi_slave_model slave_inst (.*);

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers.
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
    endfunction

    task automatic random_byte(output logic [DATA_W-1:0] b);
        for (int i = 0; i < DATA_W; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[DATA_W-2:0], lfsr[0]}; // One step per bit taken.
        end
    endtask

    // Expected status word built from the register map rules.
    function automatic spi_stat_t make_stat(input logic bsy, err, rcv, empty);
        spi_stat_t s;
        s              = '0;
        s.busy         = bsy;
        s.senderr      = err;
        s.charreceived = rcv;
        s.buffempty    = empty;
        return s;
    endfunction

    // One Wishbone classic access, held until ack.
    task automatic bus_cycle(input logic [ADDR_W-1:0] a, input logic write,
                             input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] q);
        int n;
        n = 0;
        @(posedge wr);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= d;
        do begin
            @(posedge wr);
            n = n + 1;
        end while (!ack && n < ACK_LIMIT);
        q = dat_r; // Valid while ack is high.
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        if (!ack) begin
            $display("error at %0t ns: no ack from address %0d after %0d cycles",
                     $time, a, ACK_LIMIT);
            errors = errors + 1;
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] unused;
        bus_cycle(a, 1'b1, d, unused);
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] q);
        bus_cycle(a, 1'b0, '0, q);
    endtask

    task automatic await_bytes(input int target);
        int n;
        n = 0;
        while (cap_count < target && n < FRAME_LIMIT) begin
            @(posedge wr);
            n = n + 1;
        end
        if (cap_count < target) begin
            $display("error at %0t ns: slave saw %0d bytes, waited for %0d",
                     $time, cap_count, target);
            errors = errors + 1;
        end
    endtask

    task automatic wait_ss_release;
        int n;
        n = 0;
        while (ss !== 1'b1 && n < FRAME_LIMIT) begin
            @(posedge wr);
            n = n + 1;
        end
        if (ss !== 1'b1) begin
            $display("error at %0t ns: ss stayed low for %0d cycles", $time, FRAME_LIMIT);
            errors = errors + 1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and test bookkeeping.
    //////////////////////////////////////////////////////////////////////

    task automatic expect_byte(input string name, input logic [DATA_W-1:0] exp, act);
        checks = checks + 1;
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s expected %02h, actual %02h", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic status_matches(input string name, input spi_stat_t exp, act);
        checks = checks + 1;
        if (act !== exp) begin
            $display("mismatch at %0t ns: %s expected %08b, actual %08b", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic count_matches(input string name, input int exp, act);
        checks = checks + 1;
        if (act != exp) begin
            $display("mismatch at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic open_test;
        err_mark = errors;
    endtask

    task automatic close_test(input string what);
        tests = tests + 1;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, what);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %0d %s: FAILED with %0d errors", tests, what, errors - err_mark);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests.
    //////////////////////////////////////////////////////////////////////

    task automatic fill_table;
        rows[0] = '{8'ha5, 8'h3c, 2'd0, 1'b0, 3'd0};
        rows[1] = '{8'h5a, 8'hc3, 2'd1, 1'b1, 3'd1};
        rows[2] = '{8'h81, 8'h7e, 2'd2, 1'b0, 3'd2};
        rows[3] = '{8'h0f, 8'hf0, 2'd3, 1'b1, 3'd3};
        rows[4] = '{8'he7, 8'h18, 2'd0, 1'b1, 3'd4};
        rows[5] = '{8'h01, 8'h80, 2'd1, 1'b0, 3'd5};
        rows[6] = '{8'hff, 8'h00, 2'd2, 1'b1, 3'd6};
        rows[7] = '{8'h96, 8'h69, 2'd3, 1'b0, 3'd7};
        for (int i = 8; i < N_ROWS; i++) begin
            random_byte(rows[i].tx);
            random_byte(rows[i].resp);
            rows[i].mode  = 2'(3 - i % 4);
            rows[i].lsb   = 1'(i % 2);
            rows[i].presc = 3'(i % 3);
        end
    endtask

    task automatic run_row(input int i);
        reg_word_u         w;
        logic [DATA_W-1:0] q;
        int                base;
        w              = '0;
        w.ctrl.prescale = rows[i].presc;
        w.ctrl.mode     = rows[i].mode;
        w.ctrl.lsbfirst = rows[i].lsb;
        @(posedge wr);
        mode     <= rows[i].mode; // The slave follows the mode under test.
        lsbfirst <= rows[i].lsb;
        resp     <= rows[i].resp;
        write_reg(ADDR_CTRL, w.data);
        base = cap_count;
        write_reg(ADDR_DATA, rows[i].tx);
        await_bytes(base + 1);
        wait_ss_release();
        expect_byte("mosi byte", rows[i].tx, cap_byte);
        count_matches("sck idle level", int'(rows[i].mode[1]), int'(idle_sck));
        count_matches("cycles between first sck edges", 1 << rows[i].presc, edge_gap);
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after frame", make_stat(1'b0, 1'b0, 1'b1, 1'b1), w.stat);
        read_reg(ADDR_DATA, q);
        expect_byte("dat_r data", rows[i].resp, q);
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after data read", make_stat(1'b0, 1'b0, 1'b0, 1'b1), w.stat);
    endtask

    // Overrun of a full buffer, then two frames back to back.
    task automatic run_overrun;
        reg_word_u         w;
        logic [DATA_W-1:0] q;
        int                base;
        int                rises;
        w               = '0;
        w.ctrl.prescale = 3'd3; // 128 cycles per frame, room for the bus accesses.
        @(posedge wr);
        mode     <= 2'd0;
        lsbfirst <= 1'b0;
        resp     <= 8'h4b;
        write_reg(ADDR_CTRL, w.data);
        base  = cap_count;
        rises = ss_rises;
        write_reg(ADDR_DATA, 8'hc6); // Goes straight to the engine.
        write_reg(ADDR_DATA, 8'h39); // Waits in the buffer.
        write_reg(ADDR_DATA, 8'h11); // Dropped.
        write_reg(ADDR_DATA, 8'h22); // Dropped.
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after overrun", make_stat(1'b1, 1'b1, 1'b0, 1'b0), w.stat);
        w              = '0;
        w.stat.senderr = 1'b1;
        write_reg(ADDR_STAT, w.data);
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after senderr clear", make_stat(1'b1, 1'b0, 1'b0, 1'b0), w.stat);
        await_bytes(base + 1);
        expect_byte("first back-to-back byte", 8'hc6, cap_byte);
        resp <= 8'h2d; // The second frame answers with a different byte.
        await_bytes(base + 2);
        expect_byte("second back-to-back byte", 8'h39, cap_byte);
        wait_ss_release();
        count_matches("ss rising edges over two frames", 1, ss_rises - rises);
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after two frames", make_stat(1'b0, 1'b0, 1'b1, 1'b1), w.stat);
        read_reg(ADDR_DATA, q);
        expect_byte("dat_r data after overwrite", 8'h2d, q);
    endtask

    initial begin
        reg_word_u         w;
        logic [DATA_W-1:0] q;
        rst      <= 1'b1;
        cyc      <= 1'b0;
        stb      <= 1'b0;
        we       <= 1'b0;
        adr      <= '0;
        dat_w    <= '0;
        mode     <= 2'd0;
        lsbfirst <= 1'b0;
        resp     <= '0;
        fill_table();
        repeat (2) @(posedge wr);
        rst <= 1'b0;
        @(posedge wr);

        open_test();
        count_matches("ss after reset", 1, int'(ss));
        count_matches("sck after reset", 0, int'(sck));
        count_matches("mosi after reset", 1, int'(mosi));
        read_reg(ADDR_STAT, q);
        w.data = q;
        status_matches("stat after reset", make_stat(1'b0, 1'b0, 1'b0, 1'b1), w.stat);
        close_test("reset state");

        for (int i = 0; i < N_ROWS; i++) begin
            open_test();
            run_row(i);
            close_test($sformatf("row %0d mode %0d %s prescale %0d", i, rows[i].mode,
                                 rows[i].lsb ? "lsb first" : "msb first", rows[i].presc));
        end

        open_test();
        run_overrun();
        close_test("overrun and back-to-back frames");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/spi_pkg.sv
verilog/spi_frame_if.sv
verilog/spi_bus_regs.sv
verilog/spi_shift_engine.sv
verilog/spi_rx_buffer.sv
verilog/spi_master_top.sv
bench/spi_slave_model.sv
bench/spi_master_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module spi_master_tb -f src.f -Mdir obj_dir -o spi_master_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/spi_master_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
